/* logic/cache_types.sv */
package cache_types;

    // ########################################
    // address geometry
    // ########################################

    localparam int INDEX_BITS     = 3;
    localparam int OFFSET_BITS    = 5;  // 32-byte lines.
    localparam int TAG_BITS       = 32 - INDEX_BITS - OFFSET_BITS;
    localparam int WORDS_PER_LINE = 2 ** (OFFSET_BITS - 2);

    typedef enum logic [2:0] {
        idle_s,
        compare_tag_s,
        prefetch_s,
        allocate_s,
        writeback_s
    } state_t;

    typedef struct packed {
        logic [TAG_BITS-1:0]    tag;
        logic [INDEX_BITS-1:0]  index;
        logic [OFFSET_BITS-1:0] offset;
    } addr_t;

    // the memory bus sees a flat line, the word path sees eight words.
    typedef union packed {
        logic [WORDS_PER_LINE*32-1:0]   flat;
        logic [WORDS_PER_LINE-1:0][31:0] words;
    } line_u;

    // ########################################
    // CPU side
    // ########################################

    typedef struct packed {
        logic        read;
        logic        write;
        addr_t       addr;
        logic [31:0] wdata;
    } cpu_req_t;

endpackage

/* logic/mem_types.sv */
package mem_types;

    // memory is addressed in whole lines.
    localparam int LINE_ADDR_BITS = 32 - cache_types::OFFSET_BITS;

    typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;

    // ########################################
    // memory bus
    // ########################################

    // read or write stays up, with address and data held, until done.
    typedef struct packed {
        logic               read;
        logic               write;
        line_addr_t         addr;
        cache_types::line_u wdata;
    } mem_req_t;

    typedef struct packed {
        logic               done;   // one-cycle pulse.
        cache_types::line_u rdata;
    } mem_rsp_t;

endpackage

/* logic/cpu_port.sv */
module cpu_port (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_types::cpu_req_t req,
    input  cache_types::state_t   state,
    input  logic                  valid_hit,
    input  logic [31:0]           line_word,
    output cache_types::cpu_req_t held_req,
    output logic                  valid_cpu_rqst,
    output logic                  write,
    output logic [4:0]            offset,
    output logic                  cpu_resp,
    output logic [31:0]           cpu_rdata
);

    logic               held_rd;
    logic               held_wr;
    cache_types::addr_t held_addr;
    logic [31:0]        held_wdata;
    logic               capture;

    assign capture = (state == cache_types::idle_s) && (req.read || req.write);

    // the command bits are cleared once the CPU has seen its done pulse.
    always_ff @(posedge clk) begin
        if (rst) begin
            held_rd <= 1'b0;
            held_wr <= 1'b0;
        end else if (capture) begin
            held_rd <= req.read;
            held_wr <= req.write;
        end else if (cpu_resp) begin
            held_rd <= 1'b0;
            held_wr <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            held_addr  <= req.addr;
            held_wdata <= req.wdata;
        end
    end

    always_comb begin
        held_req.read  = held_rd;
        held_req.write = held_wr;
        held_req.addr  = held_addr;
        held_req.wdata = held_wdata;
    end

    assign valid_cpu_rqst = req.read || req.write;
    assign write          = req.write;
    assign offset         = held_addr.offset;

    // a miss comes back through compare_tag_s, so this covers both cases.
    assign cpu_resp  = (state == cache_types::compare_tag_s) && valid_hit;
    assign cpu_rdata = cpu_resp ? line_word : 32'd0;

endmodule

/* logic/inst_control.sv */
module inst_control (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid_cpu_rqst,
    input  logic                valid_hit,
    input  logic                dirty,
    input  logic                mem_resp,
    input  logic                write,
    input  logic [4:0]          offset,
    input  logic                prefetch_rvalid,
    output logic                active_prefetch,
    output cache_types::state_t state
);

    cache_types::state_t next_state;
    logic                mem_resp_reg;
    logic                pf_landed;
    logic                pf_trigger;

    // only fetches run ahead. stores are occasional and say nothing
    // about the next line.
    assign pf_trigger = valid_hit && !write && (offset == 5'd0) && !active_prefetch;

    // ########################################
    // state and prefetch tracking
    // ########################################

    always_ff @(posedge clk) begin
        if (rst) begin
            state           <= cache_types::idle_s;
            mem_resp_reg    <= 1'b0;
            active_prefetch <= 1'b0;
            pf_landed       <= 1'b0;
        end else begin
            state <= next_state;

            // the writeback response must not count as the fill.
            mem_resp_reg <= mem_resp && (state == cache_types::allocate_s);

            if (state == cache_types::compare_tag_s && pf_trigger) begin
                active_prefetch <= 1'b1;
                pf_landed       <= 1'b0;
            end else if (state == cache_types::idle_s && (prefetch_rvalid || pf_landed)) begin
                active_prefetch <= 1'b0;
                pf_landed       <= 1'b0;
            end else if (active_prefetch && prefetch_rvalid
                         && state != cache_types::prefetch_s) begin
                // the buffer may be drained by an allocation before the next
                // idle cycle, so its arrival is remembered here.
                pf_landed <= 1'b1;
            end
        end
    end

    // ########################################
    // next state
    // ########################################

    always_comb begin
        next_state = state;
        case (state)
            cache_types::idle_s: begin
                if (valid_cpu_rqst)
                    next_state = cache_types::compare_tag_s;
            end
            cache_types::compare_tag_s: begin
                if (valid_hit) begin
                    if (pf_trigger)
                        next_state = cache_types::prefetch_s;
                    else
                        next_state = cache_types::idle_s;
                end else if (dirty) begin
                    next_state = cache_types::writeback_s;
                end else begin
                    next_state = cache_types::allocate_s;
                end
            end
            cache_types::prefetch_s: begin
                next_state = cache_types::idle_s;  // one cycle to hand off.
            end
            cache_types::writeback_s: begin
                if (mem_resp)
                    next_state = cache_types::allocate_s;
            end
            cache_types::allocate_s: begin
                if (mem_resp_reg)
                    next_state = cache_types::compare_tag_s;
            end
            default: begin
                next_state = cache_types::idle_s;
            end
        endcase
    end

endmodule

/* logic/inst_array.sv */
module inst_array #(
    parameter int NUM_SETS = 8
) (
    input  logic                             clk,
    input  logic                             rst,
    input  cache_types::state_t              state,
    input  cache_types::addr_t               addr,
    input  logic [31:0]                      wdata,
    input  logic                             write,
    input  cache_types::line_u               fill_line,
    input  logic                             mem_resp,
    output logic                             valid_hit,
    output logic                             dirty,
    output logic [31:0]                      line_word,
    output cache_types::line_u               victim_line,
    output logic [cache_types::TAG_BITS-1:0] victim_tag
);

    logic [cache_types::TAG_BITS-1:0]   tags [NUM_SETS];
    cache_types::line_u                 lines [NUM_SETS];
    logic [NUM_SETS-1:0]                valid_bits;
    logic [NUM_SETS-1:0]                dirty_bits;

    logic [cache_types::INDEX_BITS-1:0] idx;
    logic [2:0]                         word_sel;
    cache_types::line_u                 merged;
    logic                               store_hit;
    logic                               fill;

    assign idx      = addr.index;
    assign word_sel = addr.offset[4:2];  // byte bits are ignored.

    assign valid_hit = valid_bits[idx] && (tags[idx] == addr.tag);
    assign dirty     = valid_bits[idx] && dirty_bits[idx];

    assign line_word   = lines[idx].words[word_sel];
    assign victim_line = lines[idx];
    assign victim_tag  = tags[idx];

    assign store_hit = (state == cache_types::compare_tag_s) && write && valid_hit;
    assign fill      = (state == cache_types::allocate_s) && mem_resp;

    // stores replace a whole word inside the current line.
    always_comb begin
        merged                 = lines[idx];
        merged.words[word_sel] = wdata;
    end

    // ########################################
    // line state
    // ########################################

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (fill) begin
            valid_bits[idx] <= 1'b1;
            dirty_bits[idx] <= 1'b0;  // fresh from memory.
        end else if (store_hit) begin
            dirty_bits[idx] <= 1'b1;
        end
    end

    // ########################################
    // storage
    // ########################################

    always_ff @(posedge clk) begin
        if (fill) begin
            lines[idx] <= fill_line;
            tags[idx]  <= addr.tag;
        end else if (store_hit) begin
            lines[idx] <= merged;
        end
    end

endmodule

/* logic/mem_port.sv */
module mem_port (
    input  logic                             clk,
    input  logic                             rst,
    input  cache_types::state_t              state,
    input  cache_types::addr_t               addr,
    input  logic                             active_prefetch,
    input  cache_types::line_u               victim_line,
    input  logic [cache_types::TAG_BITS-1:0] victim_tag,
    output mem_types::mem_req_t              mem_req,
    input  mem_types::mem_rsp_t              mem_rsp,
    output cache_types::line_u               fill_line,
    output logic                             mem_resp,
    output logic                             prefetch_rvalid
);

    mem_types::line_addr_t line_addr;
    mem_types::line_addr_t victim_addr;
    mem_types::line_addr_t pf_addr;
    mem_types::line_addr_t buf_addr;
    cache_types::line_u    buf_line;

    logic active_q;
    logic pf_pending;  // requested but not yet on the bus.
    logic pf_busy;     // prefetch read owns the bus.
    logic buf_valid;
    logic fill_done;   // covers the extra allocate cycle.

    logic pf_rise;
    logic pf_start;
    logic pf_done;
    logic buf_hit;
    logic demand_wr;
    logic demand_rd;

    assign line_addr   = {addr.tag, addr.index};
    assign victim_addr = {victim_tag, addr.index};

    assign pf_rise  = active_prefetch && !active_q;
    assign pf_start = pf_pending
                      && state != cache_types::writeback_s
                      && state != cache_types::allocate_s;
    assign pf_done  = pf_busy && mem_rsp.done;

    assign buf_hit   = (state == cache_types::allocate_s) && !fill_done
                       && buf_valid && (buf_addr == line_addr);
    assign demand_wr = (state == cache_types::writeback_s) && !pf_busy;
    assign demand_rd = (state == cache_types::allocate_s) && !fill_done
                       && !buf_hit && !pf_busy;

    assign mem_resp        = buf_hit || ((demand_wr || demand_rd) && mem_rsp.done);
    assign fill_line       = buf_hit ? buf_line : mem_rsp.rdata;
    assign prefetch_rvalid = buf_valid;

    // ########################################
    // bus request
    // ########################################

    always_comb begin
        mem_req = '0;
        if (pf_busy) begin
            mem_req.read = 1'b1;
            mem_req.addr = pf_addr;
        end else if (demand_wr) begin
            mem_req.write = 1'b1;
            mem_req.addr  = victim_addr;
            mem_req.wdata = victim_line;
        end else if (demand_rd) begin
            mem_req.read = 1'b1;
            mem_req.addr = line_addr;
        end
    end

    // ########################################
    // prefetch buffer
    // ########################################

    always_ff @(posedge clk) begin
        if (rst) begin
            active_q   <= 1'b0;
            pf_pending <= 1'b0;
            pf_busy    <= 1'b0;
            buf_valid  <= 1'b0;
            fill_done  <= 1'b0;
        end else begin
            active_q  <= active_prefetch;
            fill_done <= (state == cache_types::allocate_s) && (fill_done || mem_resp);

            if (pf_rise)
                pf_pending <= 1'b1;
            else if (pf_start)
                pf_pending <= 1'b0;

            if (pf_start)
                pf_busy <= 1'b1;
            else if (pf_done)
                pf_busy <= 1'b0;

            if (pf_rise)
                buf_valid <= 1'b0;  // about to be replaced.
            else if (pf_done)
                buf_valid <= 1'b1;
            else if (buf_hit)
                buf_valid <= 1'b0;
            else if (demand_wr && mem_rsp.done && victim_addr == buf_addr)
                buf_valid <= 1'b0;  // newer data just went to memory.
        end
    end

    always_ff @(posedge clk) begin
        if (pf_rise)
            pf_addr <= line_addr + 1'b1;
        if (pf_done) begin
            buf_addr <= pf_addr;
            buf_line <= mem_rsp.rdata;
        end
    end

endmodule

/* logic/inst_cache.sv */
module inst_cache #(
    parameter int NUM_SETS = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_types::cpu_req_t cpu_req,
    output logic                  cpu_resp,
    output logic [31:0]           cpu_rdata,
    output mem_types::mem_req_t   mem_req,
    input  mem_types::mem_rsp_t   mem_rsp
);

    // the address split is fixed by the package.
    if (NUM_SETS != 2 ** cache_types::INDEX_BITS) begin : g_sets_check
        $error("NUM_SETS must equal 2**INDEX_BITS");
    end

    cache_types::cpu_req_t            held_req;
    cache_types::state_t              state;
    logic                             valid_cpu_rqst;
    logic                             write;
    logic [4:0]                       offset;
    logic                             valid_hit;
    logic                             dirty;
    logic [31:0]                      line_word;
    cache_types::line_u               victim_line;
    logic [cache_types::TAG_BITS-1:0] victim_tag;
    cache_types::line_u               fill_line;
    logic                             mem_resp;
    logic                             prefetch_rvalid;
    logic                             active_prefetch;

    cpu_port u_cpu_port (
        .clk            (clk),
        .rst            (rst),
        .req            (cpu_req),
        .state          (state),
        .valid_hit      (valid_hit),
        .line_word      (line_word),
        .held_req       (held_req),
        .valid_cpu_rqst (valid_cpu_rqst),
        .write          (write),
        .offset         (offset),
        .cpu_resp       (cpu_resp),
        .cpu_rdata      (cpu_rdata)
    );

    inst_control u_inst_control (
        .clk             (clk),
        .rst             (rst),
        .valid_cpu_rqst  (valid_cpu_rqst),
        .valid_hit       (valid_hit),
        .dirty           (dirty),
        .mem_resp        (mem_resp),
        .write           (write),
        .offset          (offset),
        .prefetch_rvalid (prefetch_rvalid),
        .active_prefetch (active_prefetch),
        .state           (state)
    );

    inst_array #(
        .NUM_SETS (NUM_SETS)
    ) u_inst_array (
        .clk         (clk),
        .rst         (rst),
        .state       (state),
        .addr        (held_req.addr),
        .wdata       (held_req.wdata),
        .write       (held_req.write),
        .fill_line   (fill_line),
        .mem_resp    (mem_resp),
        .valid_hit   (valid_hit),
        .dirty       (dirty),
        .line_word   (line_word),
        .victim_line (victim_line),
        .victim_tag  (victim_tag)
    );

    mem_port u_mem_port (
        .clk             (clk),
        .rst             (rst),
        .state           (state),
        .addr            (held_req.addr),
        .active_prefetch (active_prefetch),
        .victim_line     (victim_line),
        .victim_tag      (victim_tag),
        .mem_req         (mem_req),
        .mem_rsp         (mem_rsp),
        .fill_line       (fill_line),
        .mem_resp        (mem_resp),
        .prefetch_rvalid (prefetch_rvalid)
    );

endmodule

/* test/inst_cache_checker.sv */
module inst_cache_checker (
    input logic                clk,
    input logic                rst,
    input logic                cpu_resp,
    input mem_types::mem_req_t mem_req,
    input mem_types::mem_rsp_t mem_rsp
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;  // assertion failures seen so far.

    // ########################################
    // bus rules
    // ########################################

    no_read_write_overlap: assert property (
        @(posedge clk) disable iff (rst)
        !(mem_req.read && mem_req.write)
    ) else begin
        fail_count++;
        $error("memory read and write are high in the same cycle");
    end

    // a pending request keeps its command, address and data until done.
    request_held: assert property (
        @(posedge clk) disable iff (rst)
        (mem_req.read || mem_req.write) && !mem_rsp.done |=> $stable(mem_req)
    ) else begin
        fail_count++;
        $error("memory request changed before done");
    end

    single_cycle_resp: assert property (
        @(posedge clk) disable iff (rst)
        cpu_resp |=> !cpu_resp
    ) else begin
        fail_count++;
        $error("cpu_resp was high in two consecutive cycles");
    end

endmodule

bind inst_cache inst_cache_checker u_bus_checker (
    .clk      (clk),
    .rst      (rst),
    .cpu_resp (cpu_resp),
    .mem_req  (mem_req),
    .mem_rsp  (mem_rsp)
);

/* test/inst_cache_tb.sv */
module inst_cache_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int DRIVE_DELAY  = 10;
    localparam int RESP_TIMEOUT = 200;
    localparam int BUS_TIMEOUT  = 200;
    localparam int QUIET_CYCLES = 8;  // longer than any memory latency plus prefetch start.

    typedef struct {
        string       name;
        bit          is_write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_data;
        int          exp_reads;
        int          exp_writes;
        bit          exp_hit;
    } row_t;

    logic                  clk = 1'b0;
    logic                  rst = 1'b1;
    cache_types::cpu_req_t cpu_req = '0;
    logic                  cpu_resp;
    logic [31:0]           cpu_rdata;
    mem_types::mem_req_t   mem_req;
    mem_types::mem_rsp_t   mem_rsp = '0;

    row_t        rows [$];
    logic [31:0] mem_words [logic [31:0]];
    integer      seed = 32'h4cac;
    int          wait_left = 0;
    int          bus_reads = 0;
    int          bus_writes = 0;

    inst_cache #(.NUM_SETS(8)) UUT (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .cpu_resp  (cpu_resp),
        .cpu_rdata (cpu_rdata),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    always #50 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "stopping on the first error");
    endtask

    // untouched words read as their byte address with a fixed pattern.
    function automatic logic [31:0] read_word(input logic [31:0] byte_addr);
        if (mem_words.exists(byte_addr))
            return mem_words[byte_addr];
        return byte_addr ^ 32'h5a5a0000;
    endfunction

    // the bound checker counts its assertion failures.
    always @(negedge clk) begin
        assert (UUT.u_bus_checker.fail_count == 0)
            else report_failure("a bus rule assertion in the checker failed");
    end

    // ########################################
    // memory model
    // ########################################

    always @(posedge clk) begin
        cache_types::line_u line;
        logic [31:0]        base;
        #DRIVE_DELAY;
        mem_rsp.done = 1'b0;
        if (!rst && (mem_req.read || mem_req.write)) begin
            if (wait_left == 0)
                wait_left = 1 + int'($unsigned($random(seed)) % 4);  // new transfer.
            wait_left = wait_left - 1;
            if (wait_left == 0) begin
                base = {mem_req.addr, 5'b00000};
                for (int w = 0; w < 8; w++) begin
                    if (mem_req.write)
                        mem_words[base + 32'(4 * w)] = mem_req.wdata.words[w];
                    line.words[w] = read_word(base + 32'(4 * w));
                end
                if (mem_req.write)
                    bus_writes = bus_writes + 1;
                else
                    bus_reads = bus_reads + 1;
                mem_rsp.rdata = line;
                mem_rsp.done  = 1'b1;
            end
        end
    end

    // ########################################
    // stimulus table
    // ########################################

    function automatic void add_row(input string name, input bit is_write,
                                    input logic [31:0] addr, input logic [31:0] wdata,
                                    input logic [31:0] exp_data, input int exp_reads,
                                    input int exp_writes, input bit exp_hit);
        row_t r;
        r.name       = name;
        r.is_write   = is_write;
        r.addr       = addr;
        r.wdata      = wdata;
        r.exp_data   = exp_data;
        r.exp_reads  = exp_reads;
        r.exp_writes = exp_writes;
        r.exp_hit    = exp_hit;
        rows.push_back(r);
    endfunction

    task automatic wait_bus_quiet(input string name);
        int quiet;
        int cycles;
        quiet  = 0;
        cycles = 0;
        while (quiet < QUIET_CYCLES && cycles < BUS_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (mem_req.read || mem_req.write)
                quiet = 0;
            else
                quiet++;
        end
        assert (quiet >= QUIET_CYCLES)
            else report_failure($sformatf("memory bus never went idle after %s", name));
    endtask

    task automatic apply_row(input row_t r);
        int          cycles;
        logic [31:0] got;
        @(posedge clk);
        #DRIVE_DELAY;
        cpu_req.read  = !r.is_write;
        cpu_req.write = r.is_write;
        cpu_req.addr  = r.addr;
        cpu_req.wdata = r.wdata;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end while (!cpu_resp && cycles < RESP_TIMEOUT);
        assert (cpu_resp)
            else report_failure($sformatf("no cpu_resp within %0d cycles in %s",
                                          RESP_TIMEOUT, r.name));
        got = cpu_rdata;
        @(posedge clk);
        #DRIVE_DELAY;
        cpu_req = '0;  // the CPU drops the request after the done edge.
        if (r.exp_hit)
            assert (cycles == 1)
                else report_failure($sformatf("Mismatch in %s: latency expected 1, actual %0d",
                                              r.name, cycles));
        if (!r.is_write)
            assert (got === r.exp_data)
                else report_failure($sformatf("Mismatch in %s: data expected %h, actual %h",
                                              r.name, r.exp_data, got));
        wait_bus_quiet(r.name);
        assert (bus_reads == r.exp_reads)
            else report_failure($sformatf("Mismatch in %s: bus reads expected %0d, actual %0d",
                                          r.name, r.exp_reads, bus_reads));
        assert (bus_writes == r.exp_writes)
            else report_failure($sformatf("Mismatch in %s: bus writes expected %0d, actual %0d",
                                          r.name, r.exp_writes, bus_writes));
    endtask

    initial begin
        // index is addr[7:5]; offset 0 hits on reads start a prefetch.
        add_row("read_miss",        0, 32'h0000_1024, 32'h0, 32'h5a5a_1024, 1, 0, 0);
        add_row("read_hit",         0, 32'h0000_1028, 32'h0, 32'h5a5a_1028, 1, 0, 1);
        add_row("write_hit",        1, 32'h0000_102c, 32'hdead_beef, 32'h0, 1, 0, 1);
        add_row("read_after_write", 0, 32'h0000_102c, 32'h0, 32'hdead_beef, 1, 0, 1);
        add_row("evict_dirty",      0, 32'h0000_2024, 32'h0, 32'h5a5a_2024, 2, 1, 0);
        add_row("reload_written",   0, 32'h0000_102c, 32'h0, 32'hdead_beef, 3, 1, 0);
        add_row("prefetch_start",   0, 32'h0000_1020, 32'h0, 32'h5a5a_1020, 4, 1, 1);
        add_row("prefetched_line",  0, 32'h0000_1044, 32'h0, 32'h5a5a_1044, 4, 1, 0);
        add_row("hit_no_prefetch",  0, 32'h0000_1048, 32'h0, 32'h5a5a_1048, 4, 1, 1);
        add_row("write_miss",       1, 32'h0000_3064, 32'h1234_5678, 32'h0, 5, 1, 0);
        add_row("read_write_miss",  0, 32'h0000_3064, 32'h0, 32'h1234_5678, 5, 1, 1);
        add_row("evict_second",     0, 32'h0000_4064, 32'h0, 32'h5a5a_4064, 6, 2, 0);
        add_row("reload_second",    0, 32'h0000_3064, 32'h0, 32'h1234_5678, 7, 2, 0);

        repeat (3) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        repeat (5) begin
            @(negedge clk);
            assert (!cpu_resp && !mem_req.read && !mem_req.write)
                else report_failure("the cache became active after reset with no request");
        end

        foreach (rows[i])
            apply_row(rows[i]);

        $display("All tests passed!");
        $finish;
    end

endmodule

/* inst_cache.f */
logic/cache_types.sv
logic/mem_types.sv
logic/cpu_port.sv
logic/inst_control.sv
logic/inst_array.sv
logic/mem_port.sv
logic/inst_cache.sv
test/inst_cache_checker.sv
test/inst_cache_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = inst_cache_tb
FILELIST  = inst_cache.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Test failures found

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; else echo "PASS"; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
